//--- hw/host_cfg_pkg.sv
`default_nettype none

package host_cfg_pkg;

  // Configuration port widths
  localparam int unsigned CfgAddrWidth = 8;
  localparam int unsigned CfgDataWidth = 32;

  // Each counter owns one window of CounterStride bytes
  localparam int unsigned CounterStride = 16;
  localparam int unsigned StrideBits    = $clog2(CounterStride);

  // Word offsets inside a counter window
  localparam int unsigned RegOffsetWidth = StrideBits - 2;

  localparam logic [RegOffsetWidth-1:0] RegCtrlOffset   = 2'd0;
  localparam logic [RegOffsetWidth-1:0] RegThreshOffset = 2'd1;
  localparam logic [RegOffsetWidth-1:0] RegCountOffset  = 2'd2;

  // Filler word for reads outside the counter windows
  localparam logic [CfgDataWidth-1:0] UnmappedReadWord = 32'hDEADF000;

endpackage

`default_nettype wire

//--- hw/host_event_pkg.sv
`default_nettype none

package host_event_pkg;

  // Counter bank geometry
  localparam int unsigned NumCounters     = 4;
  localparam int unsigned CounterIdxWidth = $clog2(NumCounters);
  localparam int unsigned CounterWidth    = 32;

  // Event inputs and the select field that picks one of them
  localparam int unsigned NumEvents     = 5;
  localparam int unsigned EventSelWidth = 3;

  // Codes 5 to 7 are left free and count nothing
  localparam logic [EventSelWidth-1:0] EvLlcReadHit   = 3'd0;
  localparam logic [EventSelWidth-1:0] EvLlcReadMiss  = 3'd1;
  localparam logic [EventSelWidth-1:0] EvLlcWriteHit  = 3'd2;
  localparam logic [EventSelWidth-1:0] EvLlcWriteMiss = 3'd3;
  localparam logic [EventSelWidth-1:0] EvDmaPe        = 3'd4;

  localparam int unsigned CtrlWidth = 32;

  // Control register layout, enable sits in bit 0
  typedef struct packed {
    logic [CtrlWidth-EventSelWidth-3:0] reserved;
    logic [EventSelWidth-1:0]           event_sel;
    logic                               irq_en;
    logic                               enable;
  } pmu_ctrl_t;

  // One write word, read as control fields or as a raw threshold
  typedef union packed {
    pmu_ctrl_t            ctrl;
    logic [CtrlWidth-1:0] raw;
  } pmu_wdata_u;

endpackage

`default_nettype wire

//--- hw/cfg_lite_slave.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_lite_slave (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  cfg_aw_valid_i,
  input  logic [host_cfg_pkg::CfgAddrWidth-1:0] cfg_aw_addr_i,
  input  logic                                  cfg_w_valid_i,
  input  logic [host_cfg_pkg::CfgDataWidth-1:0] cfg_w_data_i,
  input  logic                                  cfg_b_ready_i,
  input  logic                                  cfg_ar_valid_i,
  input  logic [host_cfg_pkg::CfgAddrWidth-1:0] cfg_ar_addr_i,
  input  logic                                  cfg_r_ready_i,
  input  logic [host_cfg_pkg::CfgDataWidth-1:0] reg_rdata_i,
  output logic                                  cfg_b_valid_o,
  output logic                                  cfg_r_valid_o,
  output logic [host_cfg_pkg::CfgDataWidth-1:0] cfg_r_data_o,
  output logic                                  reg_we_o,
  output logic [host_cfg_pkg::CfgAddrWidth-1:0] reg_waddr_o,
  output logic [host_cfg_pkg::CfgDataWidth-1:0] reg_wdata_o,
  output logic [host_cfg_pkg::CfgAddrWidth-1:0] reg_raddr_o
);

  logic                                  b_valid_d, b_valid_q;
  logic                                  r_valid_d, r_valid_q;
  logic [host_cfg_pkg::CfgDataWidth-1:0] r_data_q;
  logic                                  wr_accept;
  logic                                  rd_accept;

  // Address channels are always ready, a pending response blocks new beats
  assign wr_accept = cfg_aw_valid_i && cfg_w_valid_i && !b_valid_q;
  assign rd_accept = cfg_ar_valid_i && !r_valid_q;

  // Register strobe lasts the acceptance cycle only
  assign reg_we_o    = wr_accept;
  assign reg_waddr_o = cfg_aw_addr_i;
  assign reg_wdata_o = cfg_w_data_i;
  assign reg_raddr_o = cfg_ar_addr_i;

  // Write response held until the master takes it
  always_comb begin
    b_valid_d = b_valid_q;
    if (wr_accept) begin
      b_valid_d = 1'b1;
    end else if (b_valid_q && cfg_b_ready_i) begin
      b_valid_d = 1'b0;
    end
  end

  // Read response follows the same set and clear rule
  always_comb begin
    r_valid_d = r_valid_q;
    if (rd_accept) begin
      r_valid_d = 1'b1;
    end else if (r_valid_q && cfg_r_ready_i) begin
      r_valid_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      b_valid_q <= b_valid_d;
      r_valid_q <= r_valid_d;
    end
  end

  // Data snapshot of the acceptance cycle, frozen while the response waits
  always_ff @(posedge clk_i) begin
    if (rd_accept) begin
      r_data_q <= reg_rdata_i;
    end
  end

  assign cfg_b_valid_o = b_valid_q;
  assign cfg_r_valid_o = r_valid_q;
  assign cfg_r_data_o  = r_data_q;

endmodule

`default_nettype wire

//--- hw/dma_evt_rx.sv
`timescale 1ns/1ps
`default_nettype none

module dma_evt_rx (
  input  logic clk_i,
  input  logic reset_i,
  input  logic valid_i,
  output logic ack_o,
  output logic valid_o
);

  // Two-stage synchronizer for the cluster level
  logic [1:0] sync_q;
  // Previous synchronized level, for edge detection
  logic       level_q;
  logic       pulse_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync_q  <= 2'b00;
      level_q <= 1'b0;
      pulse_q <= 1'b0;
    end else begin
      sync_q  <= {sync_q[0], valid_i};
      level_q <= sync_q[1];
      // One pulse per rising edge of the synchronized level
      pulse_q <= sync_q[1] && !level_q;
    end
  end

  // The cluster lowers valid once it sees the ack level
  assign ack_o   = sync_q[1];
  assign valid_o = pulse_q;

endmodule

`default_nettype wire

//--- hw/pmu_counters.sv
`timescale 1ns/1ps
`default_nettype none

module pmu_counters (
  input  logic                                     clk_i,
  input  logic                                     reset_i,
  input  logic                                     llc_read_hit_i,
  input  logic                                     llc_read_miss_i,
  input  logic                                     llc_write_hit_i,
  input  logic                                     llc_write_miss_i,
  input  logic                                     dma_evt_i,
  input  logic                                     reg_we_i,
  input  logic [host_cfg_pkg::CfgAddrWidth-1:0]    reg_waddr_i,
  input  logic [host_cfg_pkg::CfgDataWidth-1:0]    reg_wdata_i,
  input  logic [host_cfg_pkg::CfgAddrWidth-1:0]    reg_raddr_i,
  output logic [host_cfg_pkg::CfgDataWidth-1:0]    reg_rdata_o,
  output logic [host_event_pkg::NumCounters-1:0]   intr_o
);

  // Word aligned and inside one of the counter windows
  function automatic logic addr_mapped(input logic [host_cfg_pkg::CfgAddrWidth-1:0] addr);
    logic [host_cfg_pkg::CfgAddrWidth-1:0] upper;
    upper = addr >> (host_cfg_pkg::StrideBits + host_event_pkg::CounterIdxWidth);
    return (addr[1:0] == 2'b00) && (upper == '0);
  endfunction

  function automatic logic [host_event_pkg::CounterIdxWidth-1:0] addr_idx(
    input logic [host_cfg_pkg::CfgAddrWidth-1:0] addr
  );
    return addr[host_cfg_pkg::StrideBits +: host_event_pkg::CounterIdxWidth];
  endfunction

  function automatic logic [host_cfg_pkg::RegOffsetWidth-1:0] addr_off(
    input logic [host_cfg_pkg::CfgAddrWidth-1:0] addr
  );
    return addr[host_cfg_pkg::StrideBits-1:2];
  endfunction

  host_event_pkg::pmu_ctrl_t                 ctrl_q   [host_event_pkg::NumCounters];
  logic [host_event_pkg::CounterWidth-1:0]   thresh_q [host_event_pkg::NumCounters];
  logic [host_event_pkg::CounterWidth-1:0]   count_q  [host_event_pkg::NumCounters];
  logic [host_event_pkg::CounterWidth-1:0]   count_inc[host_event_pkg::NumCounters];
  logic [host_event_pkg::NumCounters-1:0]    intr_q;

  host_event_pkg::pmu_wdata_u                wdata;
  host_event_pkg::pmu_ctrl_t                 ctrl_wr;
  logic [host_event_pkg::NumEvents-1:0]      evt_vec;
  logic [2**host_event_pkg::EventSelWidth-1:0] evt_all;
  logic [host_event_pkg::NumCounters-1:0]    ctrl_we;
  logic [host_event_pkg::NumCounters-1:0]    thresh_we;
  logic [host_event_pkg::NumCounters-1:0]    evt_hit;

  assign evt_vec[host_event_pkg::EvLlcReadHit]   = llc_read_hit_i;
  assign evt_vec[host_event_pkg::EvLlcReadMiss]  = llc_read_miss_i;
  assign evt_vec[host_event_pkg::EvLlcWriteHit]  = llc_write_hit_i;
  assign evt_vec[host_event_pkg::EvLlcWriteMiss] = llc_write_miss_i;
  assign evt_vec[host_event_pkg::EvDmaPe]        = dma_evt_i;

  // Free select codes see a constant zero
  assign evt_all = {{(2**host_event_pkg::EventSelWidth-host_event_pkg::NumEvents){1'b0}}, evt_vec};

  assign wdata = reg_wdata_i;

  always_comb begin
    ctrl_wr          = wdata.ctrl;
    ctrl_wr.reserved = '0;
  end

  // Per counter write strobes and event match
  always_comb begin
    for (int i = 0; i < host_event_pkg::NumCounters; i++) begin
      logic sel;
      sel = reg_we_i && addr_mapped(reg_waddr_i) &&
            (addr_idx(reg_waddr_i) == host_event_pkg::CounterIdxWidth'(i));
      ctrl_we[i]   = sel && (addr_off(reg_waddr_i) == host_cfg_pkg::RegCtrlOffset);
      thresh_we[i] = sel && (addr_off(reg_waddr_i) == host_cfg_pkg::RegThreshOffset);
      evt_hit[i]   = ctrl_q[i].enable && evt_all[ctrl_q[i].event_sel];
      count_inc[i] = count_q[i] + host_event_pkg::CounterWidth'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < host_event_pkg::NumCounters; i++) begin
        ctrl_q[i]   <= '0;
        thresh_q[i] <= '0;
        count_q[i]  <= '0;
      end
      intr_q <= '0;
    end else begin
      for (int i = 0; i < host_event_pkg::NumCounters; i++) begin
        if (ctrl_we[i]) begin
          // New configuration restarts the counter
          ctrl_q[i]  <= ctrl_wr;
          count_q[i] <= '0;
          intr_q[i]  <= 1'b0;
        end else if (thresh_we[i]) begin
          // A threshold write also wins over a same-cycle event
          thresh_q[i] <= wdata.raw;
        end else if (evt_hit[i]) begin
          count_q[i] <= count_inc[i];
          if (ctrl_q[i].irq_en && (count_inc[i] == thresh_q[i])) begin
            intr_q[i] <= 1'b1;
          end
        end
      end
    end
  end

  // Read mux over the words of each counter window
  always_comb begin
    reg_rdata_o = host_cfg_pkg::UnmappedReadWord;
    if (addr_mapped(reg_raddr_i)) begin
      case (addr_off(reg_raddr_i))
        host_cfg_pkg::RegCtrlOffset:   reg_rdata_o = ctrl_q[addr_idx(reg_raddr_i)];
        host_cfg_pkg::RegThreshOffset: reg_rdata_o = thresh_q[addr_idx(reg_raddr_i)];
        host_cfg_pkg::RegCountOffset:  reg_rdata_o = count_q[addr_idx(reg_raddr_i)];
        default:                       reg_rdata_o = host_cfg_pkg::UnmappedReadWord;
      endcase
    end
  end

  assign intr_o = intr_q;

endmodule

`default_nettype wire

//--- hw/host_domain.sv
`timescale 1ns/1ps
`default_nettype none

module host_domain (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  // LLC event pulses
  input  logic                                   llc_read_hit_i,
  input  logic                                   llc_read_miss_i,
  input  logic                                   llc_write_hit_i,
  input  logic                                   llc_write_miss_i,
  // Cluster DMA event handshake
  input  logic                                   dma_pe_evt_valid_i,
  output logic                                   dma_pe_evt_ack_o,
  // Configuration port
  input  logic                                   cfg_aw_valid_i,
  input  logic [host_cfg_pkg::CfgAddrWidth-1:0]  cfg_aw_addr_i,
  input  logic                                   cfg_w_valid_i,
  input  logic [host_cfg_pkg::CfgDataWidth-1:0]  cfg_w_data_i,
  input  logic                                   cfg_b_ready_i,
  output logic                                   cfg_b_valid_o,
  input  logic                                   cfg_ar_valid_i,
  input  logic [host_cfg_pkg::CfgAddrWidth-1:0]  cfg_ar_addr_i,
  input  logic                                   cfg_r_ready_i,
  output logic                                   cfg_r_valid_o,
  output logic [host_cfg_pkg::CfgDataWidth-1:0]  cfg_r_data_o,
  // Sticky threshold interrupts
  output logic [host_event_pkg::NumCounters-1:0] pmu_intr_o
);

  logic                                  reg_we;
  logic [host_cfg_pkg::CfgAddrWidth-1:0] reg_waddr;
  logic [host_cfg_pkg::CfgDataWidth-1:0] reg_wdata;
  logic [host_cfg_pkg::CfgAddrWidth-1:0] reg_raddr;
  logic [host_cfg_pkg::CfgDataWidth-1:0] reg_rdata;
  logic                                  dma_evt;

  cfg_lite_slave i_cfg_lite_slave (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .cfg_aw_valid_i ( cfg_aw_valid_i ),
    .cfg_aw_addr_i  ( cfg_aw_addr_i  ),
    .cfg_w_valid_i  ( cfg_w_valid_i  ),
    .cfg_w_data_i   ( cfg_w_data_i   ),
    .cfg_b_ready_i  ( cfg_b_ready_i  ),
    .cfg_ar_valid_i ( cfg_ar_valid_i ),
    .cfg_ar_addr_i  ( cfg_ar_addr_i  ),
    .cfg_r_ready_i  ( cfg_r_ready_i  ),
    .reg_rdata_i    ( reg_rdata      ),
    .cfg_b_valid_o  ( cfg_b_valid_o  ),
    .cfg_r_valid_o  ( cfg_r_valid_o  ),
    .cfg_r_data_o   ( cfg_r_data_o   ),
    .reg_we_o       ( reg_we         ),
    .reg_waddr_o    ( reg_waddr      ),
    .reg_wdata_o    ( reg_wdata      ),
    .reg_raddr_o    ( reg_raddr      )
  );

  // Edge propagator receiver for the cluster DMA event
  dma_evt_rx i_dma_evt_rx (
    .clk_i   ( clk_i              ),
    .reset_i ( reset_i            ),
    .valid_i ( dma_pe_evt_valid_i ),
    .ack_o   ( dma_pe_evt_ack_o   ),
    .valid_o ( dma_evt            )
  );

  pmu_counters i_pmu_counters (
    .clk_i            ( clk_i            ),
    .reset_i          ( reset_i          ),
    .llc_read_hit_i   ( llc_read_hit_i   ),
    .llc_read_miss_i  ( llc_read_miss_i  ),
    .llc_write_hit_i  ( llc_write_hit_i  ),
    .llc_write_miss_i ( llc_write_miss_i ),
    .dma_evt_i        ( dma_evt          ),
    .reg_we_i         ( reg_we           ),
    .reg_waddr_i      ( reg_waddr        ),
    .reg_wdata_i      ( reg_wdata        ),
    .reg_raddr_i      ( reg_raddr        ),
    .reg_rdata_o      ( reg_rdata        ),
    .intr_o           ( pmu_intr_o       )
  );

endmodule

`default_nettype wire

//--- verification/tb_host_domain.sv
`timescale 1ns/1ps
`default_nettype none

module tb_host_domain;

  localparam int          WaitLimit  = 40;
  localparam logic [31:0] FillerWord = 32'hDEADF000;
  localparam logic [31:0] CtrlMask   = 32'h0000_001F;

  logic clk_i = 1'b0;
  logic reset_i;
  logic llc_read_hit_i, llc_read_miss_i, llc_write_hit_i, llc_write_miss_i;
  logic dma_pe_evt_valid_i, dma_pe_evt_ack_o;
  logic cfg_aw_valid_i, cfg_w_valid_i, cfg_b_ready_i, cfg_b_valid_o;
  logic cfg_ar_valid_i, cfg_r_ready_i, cfg_r_valid_o;
  logic [host_cfg_pkg::CfgAddrWidth-1:0]  cfg_aw_addr_i, cfg_ar_addr_i;
  logic [host_cfg_pkg::CfgDataWidth-1:0]  cfg_w_data_i, cfg_r_data_o;
  logic [host_event_pkg::NumCounters-1:0] pmu_intr_o;

  // Reference model of the counter bank
  logic [31:0] m_ctrl   [4];
  logic [31:0] m_thresh [4];
  logic [31:0] m_count  [4];
  logic [3:0]  m_intr;

  string test_name;
  int    test_errors;
  int    tests_passed;
  int    tests_failed;

  always #5 clk_i = ~clk_i;

  host_domain i_host_domain (
    .clk_i              ( clk_i              ),
    .reset_i            ( reset_i            ),
    .llc_read_hit_i     ( llc_read_hit_i     ),
    .llc_read_miss_i    ( llc_read_miss_i    ),
    .llc_write_hit_i    ( llc_write_hit_i    ),
    .llc_write_miss_i   ( llc_write_miss_i   ),
    .dma_pe_evt_valid_i ( dma_pe_evt_valid_i ),
    .dma_pe_evt_ack_o   ( dma_pe_evt_ack_o   ),
    .cfg_aw_valid_i     ( cfg_aw_valid_i     ),
    .cfg_aw_addr_i      ( cfg_aw_addr_i      ),
    .cfg_w_valid_i      ( cfg_w_valid_i      ),
    .cfg_w_data_i       ( cfg_w_data_i       ),
    .cfg_b_ready_i      ( cfg_b_ready_i      ),
    .cfg_b_valid_o      ( cfg_b_valid_o      ),
    .cfg_ar_valid_i     ( cfg_ar_valid_i     ),
    .cfg_ar_addr_i      ( cfg_ar_addr_i      ),
    .cfg_r_ready_i      ( cfg_r_ready_i      ),
    .cfg_r_valid_o      ( cfg_r_valid_o      ),
    .cfg_r_data_o       ( cfg_r_data_o       ),
    .pmu_intr_o         ( pmu_intr_o         )
  );

  // Inputs change 1 ns after the rising edge
  task automatic tick();
    @(posedge clk_i);
    #1;
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("error %s %s expected %h actual %h", test_name, what, exp, act);
    test_errors++;
  endtask

  task automatic report_timeout(input string what);
    $display("%s: gave up waiting for %s", test_name, what);
    test_errors++;
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    if (test_errors == 0) begin
      $display("%s: ok", test_name);
      tests_passed++;
    end else begin
      $display("%s: %0d errors", test_name, test_errors);
      tests_failed++;
    end
  endtask

  function automatic logic [7:0] reg_addr(input int idx, input int off);
    return 8'(idx * 16 + off * 4);
  endfunction

  function automatic int short_hold();
    return int'($urandom_range(0, 3));
  endfunction

  // Expected read data from the register map rules
  function automatic logic [31:0] model_read(input logic [7:0] addr);
    int idx;
    int off;
    idx = int'(addr[5:4]);
    off = int'(addr[3:2]);
    if (addr[1:0] != 2'b00 || addr[7:6] != 2'b00) begin
      return FillerWord;
    end
    case (off)
      0:       return m_ctrl[idx];
      1:       return m_thresh[idx];
      2:       return m_count[idx];
      default: return FillerWord;
    endcase
  endfunction

  // Count writes and unmapped writes leave the model untouched
  task automatic model_write(input logic [7:0] addr, input logic [31:0] data);
    int idx;
    int off;
    idx = int'(addr[5:4]);
    off = int'(addr[3:2]);
    if (addr[1:0] == 2'b00 && addr[7:6] == 2'b00) begin
      if (off == 0) begin
        m_ctrl[idx]  = data & CtrlMask;
        m_count[idx] = '0;
        m_intr[idx]  = 1'b0;
      end else if (off == 1) begin
        m_thresh[idx] = data;
      end
    end
  endtask

  // Bit n of ev is event code n
  task automatic apply_events(input logic [4:0] ev);
    int sel;
    for (int i = 0; i < 4; i++) begin
      sel = int'(m_ctrl[i][4:2]);
      if (m_ctrl[i][0] && sel < 5 && ev[sel]) begin
        m_count[i] = m_count[i] + 32'd1;
        if (m_ctrl[i][1] && m_count[i] == m_thresh[i]) begin
          m_intr[i] = 1'b1;
        end
      end
    end
  endtask

  task automatic drive_llc(input logic [3:0] ev);
    llc_read_hit_i   = ev[0];
    llc_read_miss_i  = ev[1];
    llc_write_hit_i  = ev[2];
    llc_write_miss_i = ev[3];
  endtask

  // Ready stays low for hold cycles, one ignored write is issued meanwhile
  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, input int hold);
    int waited;
    cfg_aw_valid_i = 1'b1;
    cfg_aw_addr_i  = addr;
    cfg_w_valid_i  = 1'b1;
    cfg_w_data_i   = data;
    tick();
    cfg_aw_valid_i = 1'b0;
    cfg_w_valid_i  = 1'b0;
    waited = 0;
    while (!cfg_b_valid_o && waited < WaitLimit) begin
      tick();
      waited++;
    end
    if (!cfg_b_valid_o) begin
      report_timeout("a write response");
    end else begin
      for (int k = 0; k < hold; k++) begin
        cfg_aw_valid_i = (k == 0);
        cfg_w_valid_i  = (k == 0);
        cfg_w_data_i   = ~data;
        tick();
        if (cfg_b_valid_o !== 1'b1) begin
          report_mismatch("b_valid under back-pressure", 32'd1, 32'(cfg_b_valid_o));
        end
      end
      cfg_aw_valid_i = 1'b0;
      cfg_w_valid_i  = 1'b0;
      cfg_b_ready_i  = 1'b1;
      tick();
      cfg_b_ready_i  = 1'b0;
    end
  endtask

  task automatic read_reg(input logic [7:0] addr, input int hold, output logic [31:0] data);
    int waited;
    cfg_ar_valid_i = 1'b1;
    cfg_ar_addr_i  = addr;
    tick();
    cfg_ar_valid_i = 1'b0;
    waited = 0;
    while (!cfg_r_valid_o && waited < WaitLimit) begin
      tick();
      waited++;
    end
    data = cfg_r_data_o;
    if (!cfg_r_valid_o) begin
      report_timeout("a read response");
    end else begin
      for (int k = 0; k < hold; k++) begin
        cfg_ar_valid_i = (k == 0);
        cfg_ar_addr_i  = addr ^ 8'h04;
        tick();
        if (cfg_r_valid_o !== 1'b1 || cfg_r_data_o !== data) begin
          report_mismatch("read data under back-pressure", data, cfg_r_data_o);
        end
      end
      cfg_ar_valid_i = 1'b0;
      cfg_r_ready_i  = 1'b1;
      tick();
      cfg_r_ready_i  = 1'b0;
    end
  endtask

  task automatic program_reg(input int idx, input int off, input logic [31:0] data,
                             input int hold);
    model_write(reg_addr(idx, off), data);
    write_reg(reg_addr(idx, off), data, hold);
  endtask

  task automatic expect_reg(input logic [7:0] addr, input string what, input int hold);
    logic [31:0] data;
    read_reg(addr, hold, data);
    if (data !== model_read(addr)) begin
      report_mismatch(what, model_read(addr), data);
    end
  endtask

  initial begin
    logic [31:0] word;
    logic [2:0]  sel;
    logic [3:0]  ev;
    int          n;
    int          waited;
    logic        seen;

    void'($urandom(12));
    reset_i            = 1'b1;
    dma_pe_evt_valid_i = 1'b0;
    cfg_aw_valid_i     = 1'b0;
    cfg_aw_addr_i      = '0;
    cfg_w_valid_i      = 1'b0;
    cfg_w_data_i       = '0;
    cfg_b_ready_i      = 1'b0;
    cfg_ar_valid_i     = 1'b0;
    cfg_ar_addr_i      = '0;
    cfg_r_ready_i      = 1'b0;
    drive_llc(4'b0000);
    for (int i = 0; i < 4; i++) begin
      m_ctrl[i]   = '0;
      m_thresh[i] = '0;
      m_count[i]  = '0;
    end
    m_intr       = '0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (10) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    tick();

    begin_test("reset_state");
    if ({cfg_b_valid_o, cfg_r_valid_o, dma_pe_evt_ack_o, pmu_intr_o} !== 7'd0) begin
      report_mismatch("control outputs", 32'd0,
                      32'({cfg_b_valid_o, cfg_r_valid_o, dma_pe_evt_ack_o, pmu_intr_o}));
    end
    for (int i = 0; i < 4; i++) begin
      for (int off = 0; off < 3; off++) begin
        expect_reg(reg_addr(i, off), "reset register", short_hold());
      end
    end
    // Spare word, outside the windows, and an unaligned address
    expect_reg(8'h0C, "unmapped read", short_hold());
    expect_reg(8'h02, "unmapped read", short_hold());
    expect_reg(8'($urandom_range(64, 255)), "unmapped read", short_hold());
    end_test();

    begin_test("write_readback");
    for (int i = 0; i < 4; i++) begin
      program_reg(i, 0, $urandom, short_hold());
      expect_reg(reg_addr(i, 0), "control", short_hold());
      program_reg(i, 1, $urandom, short_hold());
      expect_reg(reg_addr(i, 1), "threshold", short_hold());
      program_reg(i, 2, $urandom, short_hold());
      expect_reg(reg_addr(i, 2), "count after write", short_hold());
    end
    end_test();

    begin_test("event_counting");
    // Two enabled counters, one disabled, one on a free select code
    for (int i = 0; i < 4; i++) begin
      sel = (i == 3) ? 3'($urandom_range(5, 7)) : 3'($urandom_range(0, 3));
      program_reg(i, 0, {27'd0, sel, 1'b0, (i != 2)}, short_hold());
    end
    for (int k = 0; k < 300; k++) begin
      ev = 4'($urandom);
      drive_llc(ev);
      apply_events({1'b0, ev});
      tick();
    end
    drive_llc(4'b0000);
    for (int i = 0; i < 4; i++) begin
      expect_reg(reg_addr(i, 2), "event count", short_hold());
    end
    end_test();

    begin_test("dma_events");
    program_reg(0, 0, {27'd0, host_event_pkg::EvDmaPe, 1'b0, 1'b1}, short_hold());
    n = int'($urandom_range(3, 10));
    for (int k = 0; k < n; k++) begin
      repeat (int'($urandom_range(0, 4))) tick();
      dma_pe_evt_valid_i = 1'b1;
      waited = 0;
      while (!dma_pe_evt_ack_o && waited < WaitLimit) begin
        tick();
        waited++;
      end
      seen = dma_pe_evt_ack_o;
      if (!seen) begin
        report_timeout("the DMA event ack");
      end
      dma_pe_evt_valid_i = 1'b0;
      waited = 0;
      while (dma_pe_evt_ack_o && waited < WaitLimit) begin
        tick();
        waited++;
      end
      if (dma_pe_evt_ack_o) begin
        report_timeout("the DMA event ack to fall");
      end else if (seen) begin
        apply_events(5'b10000);
      end
    end
    for (int i = 0; i < 4; i++) begin
      expect_reg(reg_addr(i, 2), "DMA event count", short_hold());
    end
    end_test();

    begin_test("threshold_irq");
    program_reg(1, 1, 32'($urandom_range(3, 8)), short_hold());
    word = {27'd0, 3'($urandom_range(0, 3)), 1'b1, 1'b1};
    program_reg(1, 0, word, short_hold());
    for (int k = 0; k < 60; k++) begin
      ev = 4'($urandom);
      drive_llc(ev);
      apply_events({1'b0, ev});
      tick();
      if (pmu_intr_o !== m_intr) begin
        report_mismatch("interrupt", 32'(m_intr), 32'(pmu_intr_o));
      end
    end
    drive_llc(4'b0000);
    if (pmu_intr_o[1] !== 1'b1) begin
      report_mismatch("interrupt after threshold", 32'd1, 32'(pmu_intr_o[1]));
    end
    // Rewriting the control word restarts the counter
    program_reg(1, 0, word, short_hold());
    if (pmu_intr_o !== m_intr) begin
      report_mismatch("interrupt after control write", 32'(m_intr), 32'(pmu_intr_o));
    end
    expect_reg(reg_addr(1, 2), "count after control write", short_hold());
    end_test();

    begin_test("back_pressure");
    for (int k = 0; k < 4; k++) begin
      n = int'($urandom_range(0, 3));
      program_reg(n, 1, $urandom, int'($urandom_range(3, 12)));
      expect_reg(reg_addr(n, 1), "held threshold", int'($urandom_range(3, 12)));
      expect_reg(reg_addr(n, 0), "held control", int'($urandom_range(3, 12)));
      expect_reg(reg_addr(n, 2), "held count", int'($urandom_range(3, 12)));
    end
    end_test();

    $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
hw/host_cfg_pkg.sv
hw/host_event_pkg.sv
hw/cfg_lite_slave.sv
hw/dma_evt_rx.sv
hw/pmu_counters.sv
hw/host_domain.sv
verification/tb_host_domain.sv

//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module tb_host_domain

sim:
	verilator --binary --timing -f tb.f --top-module tb_host_domain -Mdir obj_dir
	./obj_dir/Vtb_host_domain | tee sim.log
	grep -q "\*\*\* TEST PASSED \*\*\*" sim.log

clean:
	rm -rf obj_dir sim.log
